//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= stats_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
design/stats_pkg.sv
design/stats_cnt.sv
design/stats_bank.sv
design/stats_rd_arb.sv
design/stats_dump.sv
design/stats_top.sv
verification/stats_assert.sv
verification/stats_tb.sv

//--- design/stats_bank.sv
`default_nettype none

module stats_bank #(
  parameter  int NUM_STATS   = 8,
  parameter  int STAT_STAGES = 1,
  localparam int IDX_W       = (NUM_STATS > 1) ? $clog2(NUM_STATS) : 1
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire [NUM_STATS-1:0] stat_inc,
  input  wire [NUM_STATS-1:0] stat_dec,
  input  wire [NUM_STATS-1:0] stat_clr,
  input  wire [IDX_W-1:0]     rd_idx,
  input  wire                 rd_clr,
  output stats_pkg::stat_t    rd_data
);

  stats_pkg::stat_t cnt_arr [NUM_STATS];

  for (genvar i = 0; i < NUM_STATS; i++) begin : g_cnt
    logic sel_clr;

    // only the addressed counter sees the clear-on-read.
    assign sel_clr = rd_clr && (rd_idx == IDX_W'(i));

    stats_cnt #(
      .STAT_STAGES (STAT_STAGES)
    ) u_cnt (
      .clk    (clk),
      .rst_n  (rst_n),
      .clr    (stat_clr[i]),
      .inc    (stat_inc[i]),
      .dec    (stat_dec[i]),
      .rd_clr (sel_clr),
      .cnt    (cnt_arr[i])
    );
  end

  assign rd_data = cnt_arr[rd_idx];

endmodule

`default_nettype wire

//--- design/stats_cnt.sv
`default_nettype none

module stats_cnt #(
  parameter int STAT_STAGES = 1
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              clr,
  input  wire              inc,
  input  wire              dec,
  input  wire              rd_clr,
  output stats_pkg::stat_t cnt
);

  logic inc_d;
  logic dec_d;
  logic clr_d;

  if (STAT_STAGES == 0) begin : g_direct
    assign inc_d = inc;
    assign dec_d = dec;
    assign clr_d = clr;
  end else begin : g_pipe
    logic [STAT_STAGES-1:0] inc_q;
    logic [STAT_STAGES-1:0] dec_q;
    logic [STAT_STAGES-1:0] clr_q;

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        inc_q <= '0;
        dec_q <= '0;
        clr_q <= '0;
      end else begin
        inc_q[0] <= inc;
        dec_q[0] <= dec;
        clr_q[0] <= clr;
        for (int i = 1; i < STAT_STAGES; i++) begin
          inc_q[i] <= inc_q[i-1];
          dec_q[i] <= dec_q[i-1];
          clr_q[i] <= clr_q[i-1];
        end
      end
    end

    assign inc_d = inc_q[STAT_STAGES-1];
    assign dec_d = dec_q[STAT_STAGES-1];
    assign clr_d = clr_q[STAT_STAGES-1];
  end

  // clear-on-read wins over everything, then the delayed clear.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (rd_clr || clr_d) begin
      cnt <= '0;
    end else if (inc_d && !dec_d) begin
      cnt <= cnt + stats_pkg::stat_t'(1);
    end else if (dec_d && !inc_d) begin
      cnt <= cnt - stats_pkg::stat_t'(1);
    end
  end

endmodule

`default_nettype wire

//--- design/stats_dump.sv
`default_nettype none

module stats_dump #(
  parameter  int NUM_STATS    = 8,
  parameter  int DUMP_CREDITS = 4,
  localparam int IDX_W        = (NUM_STATS > 1) ? $clog2(NUM_STATS) : 1
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              dump_start,
  input  wire              dump_clr,
  output logic             dump_busy,
  output logic             rd_req,
  output logic [IDX_W-1:0] rd_idx,
  output logic             rd_clr,
  input  wire              rd_valid,
  input  wire stats_pkg::stat_t rd_data,
  output logic             dump_valid,
  output logic [IDX_W-1:0] dump_idx,
  output stats_pkg::stat_t dump_data,
  input  wire              dump_credit
);

  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_STATS - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_wait,
    st_send
  } state_e;

  state_e             state;
  stats_pkg::credit_t credit_cnt;
  stats_pkg::stat_t   data_q;
  logic [IDX_W-1:0]   idx_q;
  logic               clr_q;
  logic               beat;

  assign beat = (state == st_send);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
      idx_q <= '0;
      clr_q <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (dump_start) begin
            idx_q <= '0;
            clr_q <= dump_clr;
            state <= st_read;
          end
        end
        st_read: begin
          if (rd_valid) begin
            state <= (credit_cnt != '0) ? st_send : st_wait;
          end
        end
        // stalled on credits with the value held.
        st_wait: begin
          if (credit_cnt != '0) begin
            state <= st_send;
          end
        end
        st_send: begin
          if (idx_q == LAST_IDX) begin
            state <= st_idle;
          end else begin
            idx_q <= idx_q + 1'b1;
            state <= st_read;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_read && rd_valid) begin
      data_q <= rd_data;
    end
  end

  // a returned credit and a beat in the same cycle cancel out.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_cnt <= stats_pkg::credit_t'(DUMP_CREDITS);
    end else if (dump_credit && !beat) begin
      credit_cnt <= credit_cnt + stats_pkg::credit_t'(1);
    end else if (beat && !dump_credit) begin
      credit_cnt <= credit_cnt - stats_pkg::credit_t'(1);
    end
  end

  assign dump_busy  = (state != st_idle);
  assign rd_req     = (state == st_read);
  assign rd_idx     = idx_q;
  assign rd_clr     = clr_q;
  assign dump_valid = beat;
  assign dump_idx   = idx_q;
  assign dump_data  = data_q;

endmodule

`default_nettype wire

//--- design/stats_pkg.sv
`default_nettype none

package stats_pkg;

  // one event counter value, wraps modulo 2**16.
  typedef logic [15:0] stat_t;

  // credits held by the dump engine, up to 15.
  typedef logic [3:0] credit_t;

  // which peer owns the bank read port.
  typedef enum logic {
    src_host,
    src_dump
  } rd_src_e;

endpackage

`default_nettype wire

//--- design/stats_rd_arb.sv
`default_nettype none

module stats_rd_arb #(
  parameter  int NUM_STATS = 8,
  localparam int IDX_W     = (NUM_STATS > 1) ? $clog2(NUM_STATS) : 1
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              host_rd_req,
  input  wire [IDX_W-1:0]  host_rd_idx,
  output logic             host_rd_valid,
  output stats_pkg::stat_t host_rd_data,
  input  wire              dump_rd_req,
  input  wire [IDX_W-1:0]  dump_rd_idx,
  input  wire              dump_rd_clr,
  output logic             dump_rd_valid,
  output stats_pkg::stat_t dump_rd_data,
  output logic [IDX_W-1:0] bank_rd_idx,
  output logic             bank_rd_clr,
  input  wire stats_pkg::stat_t bank_rd_data
);

  stats_pkg::rd_src_e last_src;
  stats_pkg::stat_t   rd_data_q;
  logic               host_served;
  logic               dump_served;
  logic               host_want;
  logic               dump_want;
  logic               grant_host;
  logic               grant_dump;

  // a peer stays masked from its grant until it drops the request.
  assign host_want = host_rd_req && !host_served;
  assign dump_want = dump_rd_req && !dump_served;

  always_comb begin
    grant_host = 1'b0;
    grant_dump = 1'b0;
    if (host_want && dump_want) begin
      if (last_src == stats_pkg::src_host) begin
        grant_dump = 1'b1;
      end else begin
        grant_host = 1'b1;
      end
    end else begin
      grant_host = host_want;
      grant_dump = dump_want;
    end
  end

  assign bank_rd_idx = grant_dump ? dump_rd_idx : host_rd_idx;
  assign bank_rd_clr = grant_dump && dump_rd_clr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_src      <= stats_pkg::src_dump;
      host_served   <= 1'b0;
      dump_served   <= 1'b0;
      host_rd_valid <= 1'b0;
      dump_rd_valid <= 1'b0;
    end else begin
      host_rd_valid <= grant_host;
      dump_rd_valid <= grant_dump;
      if (grant_host) begin
        last_src <= stats_pkg::src_host;
      end else if (grant_dump) begin
        last_src <= stats_pkg::src_dump;
      end
      if (!host_rd_req) begin
        host_served <= 1'b0;
      end else if (grant_host) begin
        host_served <= 1'b1;
      end
      if (!dump_rd_req) begin
        dump_served <= 1'b0;
      end else if (grant_dump) begin
        dump_served <= 1'b1;
      end
    end
  end

  // value as it stood in the grant cycle, before any clear lands.
  always_ff @(posedge clk) begin
    if (grant_host || grant_dump) begin
      rd_data_q <= bank_rd_data;
    end
  end

  assign host_rd_data = rd_data_q;
  assign dump_rd_data = rd_data_q;

endmodule

`default_nettype wire

//--- design/stats_top.sv
`default_nettype none

module stats_top #(
  parameter  int NUM_STATS    = 8,
  parameter  int STAT_STAGES  = 1,
  parameter  int DUMP_CREDITS = 4,
  localparam int IDX_W        = (NUM_STATS > 1) ? $clog2(NUM_STATS) : 1
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire [NUM_STATS-1:0] stat_inc,
  input  wire [NUM_STATS-1:0] stat_dec,
  input  wire [NUM_STATS-1:0] stat_clr,
  input  wire                 host_rd_req,
  input  wire [IDX_W-1:0]     host_rd_idx,
  output logic                host_rd_valid,
  output stats_pkg::stat_t    host_rd_data,
  input  wire                 dump_start,
  input  wire                 dump_clr,
  output logic                dump_busy,
  output logic                dump_valid,
  output logic [IDX_W-1:0]    dump_idx,
  output stats_pkg::stat_t    dump_data,
  input  wire                 dump_credit
);

  logic             dump_rd_req;
  logic [IDX_W-1:0] dump_rd_idx;
  logic             dump_rd_clr;
  logic             dump_rd_valid;
  stats_pkg::stat_t dump_rd_data;
  logic [IDX_W-1:0] bank_rd_idx;
  logic             bank_rd_clr;
  stats_pkg::stat_t bank_rd_data;

  stats_bank #(
    .NUM_STATS   (NUM_STATS),
    .STAT_STAGES (STAT_STAGES)
  ) u_bank (
    .clk      (clk),
    .rst_n    (rst_n),
    .stat_inc (stat_inc),
    .stat_dec (stat_dec),
    .stat_clr (stat_clr),
    .rd_idx   (bank_rd_idx),
    .rd_clr   (bank_rd_clr),
    .rd_data  (bank_rd_data)
  );

  stats_rd_arb #(
    .NUM_STATS (NUM_STATS)
  ) u_arb (
    .clk           (clk),
    .rst_n         (rst_n),
    .host_rd_req   (host_rd_req),
    .host_rd_idx   (host_rd_idx),
    .host_rd_valid (host_rd_valid),
    .host_rd_data  (host_rd_data),
    .dump_rd_req   (dump_rd_req),
    .dump_rd_idx   (dump_rd_idx),
    .dump_rd_clr   (dump_rd_clr),
    .dump_rd_valid (dump_rd_valid),
    .dump_rd_data  (dump_rd_data),
    .bank_rd_idx   (bank_rd_idx),
    .bank_rd_clr   (bank_rd_clr),
    .bank_rd_data  (bank_rd_data)
  );

  stats_dump #(
    .NUM_STATS    (NUM_STATS),
    .DUMP_CREDITS (DUMP_CREDITS)
  ) u_dump (
    .clk         (clk),
    .rst_n       (rst_n),
    .dump_start  (dump_start),
    .dump_clr    (dump_clr),
    .dump_busy   (dump_busy),
    .rd_req      (dump_rd_req),
    .rd_idx      (dump_rd_idx),
    .rd_clr      (dump_rd_clr),
    .rd_valid    (dump_rd_valid),
    .rd_data     (dump_rd_data),
    .dump_valid  (dump_valid),
    .dump_idx    (dump_idx),
    .dump_data   (dump_data),
    .dump_credit (dump_credit)
  );

endmodule

`default_nettype wire

//--- verification/stats_assert.sv
`default_nettype none

module stats_assert #(
  parameter int DUMP_CREDITS = 4
) (
  input wire                     clk,
  input wire                     rst_n,
  input wire                     beat,
  input wire stats_pkg::credit_t credit_cnt,
  input wire                     valid_a,
  input wire                     valid_b
);

  // a beat may only leave with a credit in hand.
  beat_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
    beat |-> credit_cnt != '0)
    else $error("dump beat sent with no credit left");

  credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt <= stats_pkg::credit_t'(DUMP_CREDITS))
    else $error("credit count above its reset value");

  // the registered response goes to one peer at a time.
  valid_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
    !(valid_a && valid_b))
    else $error("both read responses valid together");

  beat_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    beat |=> !beat)
    else $error("dump beat longer than one cycle");

  valid_a_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    valid_a |=> !valid_a)
    else $error("read valid longer than one cycle");

  valid_b_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    valid_b |=> !valid_b)
    else $error("read valid longer than one cycle");

endmodule

bind stats_dump stats_assert #(
  .DUMP_CREDITS (DUMP_CREDITS)
) u_dump_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .beat       (dump_valid),
  .credit_cnt (credit_cnt),
  .valid_a    (rd_valid),
  .valid_b    (1'b0)
);

bind stats_rd_arb stats_assert u_arb_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .beat       (1'b0),
  .credit_cnt (stats_pkg::credit_t'(0)),
  .valid_a    (host_rd_valid),
  .valid_b    (dump_rd_valid)
);

`default_nettype wire

//--- verification/stats_tb.sv
`default_nettype none

module stats_tb;

  localparam int NUM_STATS    = 8;
  localparam int STAT_STAGES  = 1;
  localparam int DUMP_CREDITS = 4;
  localparam int IDX_W        = 3;

  logic                 clk;
  logic                 rst_n;
  logic [NUM_STATS-1:0] stat_inc;
  logic [NUM_STATS-1:0] stat_dec;
  logic [NUM_STATS-1:0] stat_clr;
  logic                 host_rd_req;
  logic [IDX_W-1:0]     host_rd_idx;
  logic                 host_rd_valid;
  stats_pkg::stat_t     host_rd_data;
  logic                 dump_start;
  logic                 dump_clr;
  logic                 dump_busy;
  logic                 dump_valid;
  logic [IDX_W-1:0]     dump_idx;
  stats_pkg::stat_t     dump_data;
  logic                 dump_credit;

  stats_pkg::stat_t model [NUM_STATS];
  int   errors;
  int   beats_seen;
  int   credits_given;
  int   sweep_base;
  int   host_reads;
  logic sweep_clr;

  stats_top #(
    .NUM_STATS    (NUM_STATS),
    .STAT_STAGES  (STAT_STAGES),
    .DUMP_CREDITS (DUMP_CREDITS)
  ) uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .stat_inc      (stat_inc),
    .stat_dec      (stat_dec),
    .stat_clr      (stat_clr),
    .host_rd_req   (host_rd_req),
    .host_rd_idx   (host_rd_idx),
    .host_rd_valid (host_rd_valid),
    .host_rd_data  (host_rd_data),
    .dump_start    (dump_start),
    .dump_clr      (dump_clr),
    .dump_busy     (dump_busy),
    .dump_valid    (dump_valid),
    .dump_idx      (dump_idx),
    .dump_data     (dump_data),
    .dump_credit   (dump_credit)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // clear first, inc with dec holds, wraps at 16 bits.
  function automatic stats_pkg::stat_t next_count(input stats_pkg::stat_t cur,
                                                  input logic inc, input logic dec,
                                                  input logic clr);
    if (clr) begin
      return '0;
    end else if (inc && !dec) begin
      return cur + stats_pkg::stat_t'(1);
    end else if (dec && !inc) begin
      return cur - stats_pkg::stat_t'(1);
    end
    return cur;
  endfunction

  task automatic check_eq(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    errors++;
  endtask

  task automatic step_events(input logic [NUM_STATS-1:0] inc, input logic [NUM_STATS-1:0] dec,
                             input logic [NUM_STATS-1:0] clr);
    @(posedge clk);
    #1;
    stat_inc = inc;
    stat_dec = dec;
    stat_clr = clr;
    for (int i = 0; i < NUM_STATS; i++) begin
      model[i] = next_count(model[i], inc[i], dec[i], clr[i]);
    end
  endtask

  // idle long enough for every event to land in its counter.
  task automatic settle();
    @(posedge clk);
    #1;
    stat_inc = '0;
    stat_dec = '0;
    stat_clr = '0;
    repeat (STAT_STAGES + 2) @(posedge clk);
  endtask

  task automatic host_read(input int idx);
    int t;
    @(posedge clk);
    #1;
    host_rd_req = 1'b1;
    host_rd_idx = IDX_W'(idx);
    t = 0;
    @(negedge clk);
    while (!host_rd_valid && t < 50) begin
      @(negedge clk);
      t++;
    end
    if (!host_rd_valid) begin
      timeout_fail("host_rd_valid");
    end else begin
      host_reads++;
    end
    @(posedge clk);
    #1;
    host_rd_req = 1'b0;
  endtask

  task automatic read_all();
    for (int i = 0; i < NUM_STATS; i++) begin
      host_read(i);
    end
  endtask

  task automatic run_dump(input logic clr_all);
    int t;
    @(posedge clk);
    #1;
    sweep_base = beats_seen;
    sweep_clr = clr_all;
    dump_start = 1'b1;
    dump_clr = clr_all;
    @(posedge clk);
    #1;
    dump_start = 1'b0;
    dump_clr = 1'b0;
    t = 0;
    while (dump_busy && t < 2000) begin
      @(negedge clk);
      t++;
    end
    if (dump_busy) begin
      timeout_fail("dump_busy to fall");
    end
    check_eq("dump beat count", beats_seen - sweep_base, NUM_STATS);
    t = 0;
    while (credits_given < beats_seen && t < 500) begin
      @(negedge clk);
      t++;
    end
    if (credits_given < beats_seen) begin
      timeout_fail("credits to return");
    end
    @(posedge clk);
  endtask

  task automatic report(input string name, input int err_before);
    $display("test %s: %s", name, (errors == err_before) ? "ok" : "mismatch");
  endtask

  // a credit pulse in the current cycle is not yet seen by the engine.
  always @(negedge clk) begin : compare
    int idx;
    if (rst_n && host_rd_valid) begin
      check_eq($sformatf("host read idx %0d", host_rd_idx), int'(host_rd_data),
               int'(model[host_rd_idx]));
    end
    if (rst_n && dump_valid) begin
      idx = beats_seen - sweep_base;
      check_eq("dump beat index", int'(dump_idx), idx);
      check_eq($sformatf("dump data idx %0d", dump_idx), int'(dump_data),
               int'(model[dump_idx]));
      check_eq("beats without credit in limit",
               int'(beats_seen + 1 - credits_given + int'(dump_credit) <= DUMP_CREDITS), 1);
      if (sweep_clr) begin
        model[dump_idx] = '0;
      end
      beats_seen++;
    end
  end

  // credits come back slowly at about one cycle in four.
  always @(posedge clk) begin
    #1;
    if (beats_seen > credits_given && $urandom_range(3) == 0) begin
      dump_credit = 1'b1;
      credits_given++;
    end else begin
      dump_credit = 1'b0;
    end
  end

  initial begin
    int err0;
    int reads0;
    void'($urandom(55));
    errors = 0;
    beats_seen = 0;
    credits_given = 0;
    sweep_base = 0;
    host_reads = 0;
    sweep_clr = 1'b0;
    rst_n = 1'b0;
    stat_inc = '0;
    stat_dec = '0;
    stat_clr = '0;
    host_rd_req = 1'b0;
    host_rd_idx = '0;
    dump_start = 1'b0;
    dump_clr = 1'b0;
    dump_credit = 1'b0;
    for (int i = 0; i < NUM_STATS; i++) begin
      model[i] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    err0 = errors;
    read_all();
    report("1 reset values", err0);

    err0 = errors;
    repeat (200) begin
      step_events(NUM_STATS'($urandom), NUM_STATS'($urandom), '0);
    end
    settle();
    read_all();
    report("2 random inc/dec", err0);

    err0 = errors;
    step_events(8'h0f, 8'h00, 8'h33);
    step_events(8'h00, 8'h00, 8'hc0);
    step_events(8'h11, 8'h00, 8'h00);
    settle();
    read_all();
    report("3 clear pulses", err0);

    err0 = errors;
    run_dump(1'b0);
    report("4 dump without clear", err0);

    err0 = errors;
    run_dump(1'b1);
    read_all();
    report("5 dump with clear", err0);

    err0 = errors;
    repeat (50) begin
      step_events(NUM_STATS'($urandom), NUM_STATS'($urandom), '0);
    end
    settle();
    reads0 = host_reads;
    fork
      run_dump(1'b0);
      read_all();
    join
    check_eq("host reads during dump", host_reads - reads0, NUM_STATS);
    report("6 host reads during dump", err0);

    $display("summary: %0d host reads, %0d dump beats, %0d errors",
             host_reads, beats_seen, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
